// ==== src/game_pkg.sv ====
// Arcade video timing constants
`default_nettype none

package game_pkg;

    // Counter width shared by H and V
    localparam int cnt_w = 9;

    // Line and frame length, 384 pixels by 262 lines
    localparam logic [cnt_w-1:0] h_total = 9'd384;
    localparam logic [cnt_w-1:0] v_total = 9'd262;

    // H blanked from this count up to the end of the line
    localparam logic [cnt_w-1:0] h_blank_start = 9'd256;

    // V active window is [v_blank_end, v_blank_start)
    localparam logic [cnt_w-1:0] v_blank_start = 9'd240;
    localparam logic [cnt_w-1:0] v_blank_end   = 9'd16;

    // Sync pulses, low over [start, end)
    localparam logic [cnt_w-1:0] hs_start = 9'd296;
    localparam logic [cnt_w-1:0] hs_end   = 9'd328;
    localparam logic [cnt_w-1:0] vs_start = 9'd244;
    localparam logic [cnt_w-1:0] vs_end   = 9'd248;

    // Download address bits 11..8 select the color PROM
    localparam logic [3:0] prom_bank_red   = 4'd0;
    localparam logic [3:0] prom_bank_green = 4'd1;
    localparam logic [3:0] prom_bank_blue  = 4'd2;

endpackage

`default_nettype wire

// ==== src/video_timer.sv ====
// Pixel rate video timer
`default_nettype none
`timescale 1ns/10ps

module video_timer (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          pxl_cen,
    input  wire                          video_flip,
    output logic [game_pkg::cnt_w-1:0]   h,
    output logic [game_pkg::cnt_w-1:0]   v,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic                         hs,
    output logic                         vs
);
    import game_pkg::*;

    logic [cnt_w-1:0] h_cnt;
    logic [cnt_w-1:0] v_cnt;
    logic [cnt_w-1:0] h_next;
    logic [cnt_w-1:0] v_next;

    // Next counter values, used for the counters and every derived output
    always_comb begin
        h_next = h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == h_total - 1'b1) begin
            h_next = '0;
            if (v_cnt == v_total - 1'b1) begin
                v_next = '0;
            end else begin
                v_next = v_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
            h     <= '0;
            v     <= '0;
            lhbl  <= 1'b0;
            lvbl  <= 1'b0;
            hs    <= 1'b1;
            vs    <= 1'b1;
        end else if (pxl_cen) begin
            h_cnt <= h_next;
            v_cnt <= v_next;
            // Flip mirrors the low 8 bits only
            if (video_flip) begin
                h <= {h_next[cnt_w-1], ~h_next[7:0]};
                v <= {v_next[cnt_w-1], ~v_next[7:0]};
            end else begin
                h <= h_next;
                v <= v_next;
            end
            // Blanking and sync always from the raw count
            lhbl <= h_next < h_blank_start;
            lvbl <= (v_next >= v_blank_end) && (v_next < v_blank_start);
            hs   <= !((h_next >= hs_start) && (h_next < hs_end));
            vs   <= !((v_next >= vs_start) && (v_next < vs_end));
        end
    end

endmodule

`default_nettype wire

// ==== src/prom_loader.sv ====
// Download stream decoder
`default_nettype none
`timescale 1ns/10ps

module prom_loader #(
    parameter logic [25:0] map_start  = 26'h020000,
    parameter logic [25:0] scr_start  = 26'h030000,
    parameter logic [25:0] obj_start  = 26'h060000,
    parameter logic [25:0] prom_start = 26'h0a0000
) (
    input  wire  [25:0] ioctl_addr,
    input  wire  [21:0] prog_addr,
    input  wire  [7:0]  prog_data,
    input  wire         prom_we,
    output logic [21:0] post_addr,
    output logic [7:0]  prom_index,
    output logic [3:0]  prom_din,
    output logic        prom_red_we,
    output logic        prom_green_we,
    output logic        prom_blue_we
);
    import game_pkg::*;

    logic [3:0] bank;
    logic       in_map;
    logic       in_obj;

    // Table select lives in address bits 11..8
    assign bank = ioctl_addr[11:8];

    assign prom_red_we   = prom_we && (bank == prom_bank_red);
    assign prom_green_we = prom_we && (bank == prom_bank_green);
    assign prom_blue_we  = prom_we && (bank == prom_bank_blue);

    // Color PROMs are 256 x 4
    assign prom_index = prog_addr[7:0];
    assign prom_din   = prog_data[3:0];

    // Region decode on the raw download address
    assign in_map = (ioctl_addr >= map_start) && (ioctl_addr < scr_start);
    assign in_obj = (ioctl_addr >= obj_start) && (ioctl_addr < prom_start);

    // Undo the board's address scrambling before the SDRAM write
    always_comb begin
        post_addr = prog_addr;
        if (in_map) begin
            // Bit 3 moves down to bit 0
            post_addr[3:0] = {prog_addr[2:0], prog_addr[3]};
        end else if (in_obj) begin
            // Bit 5 moves down to bit 1
            post_addr[5:1] = {prog_addr[4:1], prog_addr[5]};
        end
    end

endmodule

`default_nettype wire

// ==== src/cab_input.sv ====
// Cabinet input conditioning
`default_nettype none
`timescale 1ns/10ps

module cab_input (
    input  wire         clk,
    input  wire         arst_n,
    input  wire  [6:0]  joystick1,
    input  wire  [6:0]  joystick2,
    input  wire         dip_flip,
    output logic [6:0]  joy1_out,
    output logic [6:0]  joy2_out,
    output logic        video_flip
);

    // Button 3 also presses buttons 1 and 2, so the loop needs one button
    function automatic logic [6:0] merge_fire(input logic [6:0] joy);
        logic [6:0] res;
        res      = joy;
        res[5:4] = joy[5:4] | {2{joy[6]}};
        return res;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            joy1_out   <= '0;
            joy2_out   <= '0;
            video_flip <= 1'b0;
        end else begin
            joy1_out   <= merge_fire(joystick1);
            joy2_out   <= merge_fire(joystick2);
            video_flip <= dip_flip;
        end
    end

endmodule

`default_nettype wire

// ==== src/color_mixer.sv ====
// PROM based color mixer
`default_nettype none
`timescale 1ns/10ps

module color_mixer (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         pxl_cen,
    input  wire  [7:0]  pxl_code,
    input  wire         lhbl,
    input  wire         lvbl,
    input  wire  [7:0]  prom_index,
    input  wire  [3:0]  prom_din,
    input  wire         prom_red_we,
    input  wire         prom_green_we,
    input  wire         prom_blue_we,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue
);

    // One 256 x 4 table per component
    logic [3:0] red_prom   [0:255];
    logic [3:0] green_prom [0:255];
    logic [3:0] blue_prom  [0:255];

    logic       active;

    assign active = lhbl && lvbl;

    // Download writes
    always_ff @(posedge clk) begin
        if (prom_red_we) begin
            red_prom[prom_index] <= prom_din;
        end
        if (prom_green_we) begin
            green_prom[prom_index] <= prom_din;
        end
        if (prom_blue_we) begin
            blue_prom[prom_index] <= prom_din;
        end
    end

    // Lookup at the pixel strobe, black while blanked
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else if (pxl_cen) begin
            if (active) begin
                red   <= red_prom[pxl_code];
                green <= green_prom[pxl_code];
                blue  <= blue_prom[pxl_code];
            end else begin
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/arcade_game.sv ====
// Arcade video glue top level
`default_nettype none
`timescale 1ns/10ps

module arcade_game #(
    parameter logic [25:0] map_start  = 26'h020000,
    parameter logic [25:0] scr_start  = 26'h030000,
    parameter logic [25:0] obj_start  = 26'h060000,
    parameter logic [25:0] prom_start = 26'h0a0000
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          pxl_cen,
    input  wire  [7:0]                   pxl_code,
    input  wire  [6:0]                   joystick1,
    input  wire  [6:0]                   joystick2,
    input  wire                          dip_flip,
    // Download stream
    input  wire  [25:0]                  ioctl_addr,
    input  wire  [21:0]                  prog_addr,
    input  wire  [7:0]                   prog_data,
    input  wire                          prom_we,
    // Video out
    output logic [3:0]                   red,
    output logic [3:0]                   green,
    output logic [3:0]                   blue,
    output logic                         lhbl,
    output logic                         lvbl,
    output logic                         hs,
    output logic                         vs,
    output logic [game_pkg::cnt_w-1:0]   h,
    output logic [game_pkg::cnt_w-1:0]   v,
    // Cabinet and SDRAM side
    output logic [6:0]                   joy1_out,
    output logic [6:0]                   joy2_out,
    output logic [21:0]                  post_addr
);

    logic       video_flip;
    logic       prom_red_we;
    logic       prom_green_we;
    logic       prom_blue_we;
    logic [7:0] prom_index;
    logic [3:0] prom_din;

    video_timer u_timer (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .pxl_cen    ( pxl_cen    ),
        .video_flip ( video_flip ),
        .h          ( h          ),
        .v          ( v          ),
        .lhbl       ( lhbl       ),
        .lvbl       ( lvbl       ),
        .hs         ( hs         ),
        .vs         ( vs         )
    );

    prom_loader #(
        .map_start  ( map_start  ),
        .scr_start  ( scr_start  ),
        .obj_start  ( obj_start  ),
        .prom_start ( prom_start )
    ) u_loader (
        .ioctl_addr    ( ioctl_addr    ),
        .prog_addr     ( prog_addr     ),
        .prog_data     ( prog_data     ),
        .prom_we       ( prom_we       ),
        .post_addr     ( post_addr     ),
        .prom_index    ( prom_index    ),
        .prom_din      ( prom_din      ),
        .prom_red_we   ( prom_red_we   ),
        .prom_green_we ( prom_green_we ),
        .prom_blue_we  ( prom_blue_we  )
    );

    cab_input u_cab (
        .clk        ( clk        ),
        .arst_n     ( arst_n     ),
        .joystick1  ( joystick1  ),
        .joystick2  ( joystick2  ),
        .dip_flip   ( dip_flip   ),
        .joy1_out   ( joy1_out   ),
        .joy2_out   ( joy2_out   ),
        .video_flip ( video_flip )
    );

    // Pixel code stands in for the tile and sprite layers
    color_mixer u_mixer (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .pxl_cen       ( pxl_cen       ),
        .pxl_code      ( pxl_code      ),
        .lhbl          ( lhbl          ),
        .lvbl          ( lvbl          ),
        .prom_index    ( prom_index    ),
        .prom_din      ( prom_din      ),
        .prom_red_we   ( prom_red_we   ),
        .prom_green_we ( prom_green_we ),
        .prom_blue_we  ( prom_blue_we  ),
        .red           ( red           ),
        .green         ( green         ),
        .blue          ( blue          )
    );

endmodule

`default_nettype wire

// ==== sim/arcade_game_checker.sv ====
// Video timing and blanking checker
`default_nettype none
`timescale 1ns/10ps

module arcade_game_checker (
    input wire       clk,
    input wire       arst_n,
    input wire       pxl_cen,
    input wire       lhbl,
    input wire       lvbl,
    input wire       hs,
    input wire       prom_red_we,
    input wire       prom_green_we,
    input wire       prom_blue_we,
    input wire [3:0] red,
    input wire [3:0] green,
    input wire [3:0] blue
);

    // Only one table written per cycle
    one_prom_write: assert property (@(posedge clk) disable iff (!arst_n)
        $onehot0({prom_red_we, prom_green_we, prom_blue_we}))
        else $error("more than one PROM write strobe high");

    // HS pulse sits inside horizontal blanking
    hs_in_blank: assert property (@(posedge clk) disable iff (!arst_n) !hs |-> !lhbl)
        else $error("hs low during the active part of a line");

    // Blanked pixels come out black
    black_in_blank: assert property (@(posedge clk) disable iff (!arst_n)
        (pxl_cen && !(lhbl && lvbl)) |=> ({red, green, blue} == 12'd0))
        else $error("color not black after a blanked pixel strobe");

endmodule

// Timer sync, loader strobes and mixer colors all meet at the top level
bind arcade_game arcade_game_checker video_chk (
    .clk(clk), .arst_n(arst_n), .pxl_cen(pxl_cen), .lhbl(lhbl), .lvbl(lvbl), .hs(hs),
    .prom_red_we(prom_red_we), .prom_green_we(prom_green_we),
    .prom_blue_we(prom_blue_we), .red(red), .green(green), .blue(blue)
);

`default_nettype wire

// ==== sim/arcade_game_tb.sv ====
// Arcade game testbench
`default_nettype none
`timescale 1ns/10ps

module arcade_game_tb;
    import game_pkg::*;

    localparam logic [25:0] map_start  = 26'h020000;
    localparam logic [25:0] scr_start  = 26'h030000;
    localparam logic [25:0] obj_start  = 26'h060000;
    localparam logic [25:0] prom_start = 26'h0a0000;
    localparam int frame_strobes = int'(h_total) * int'(v_total);

    logic             clk = 1'b0;
    logic             arst_n;
    logic             pxl_cen = 1'b0;
    logic [7:0]       pxl_code;
    logic [6:0]       joystick1;
    logic [6:0]       joystick2;
    logic             dip_flip;
    logic [25:0]      ioctl_addr;
    logic [21:0]      prog_addr;
    logic [7:0]       prog_data;
    logic             prom_we;
    logic [3:0]       red;
    logic [3:0]       green;
    logic [3:0]       blue;
    logic             lhbl;
    logic             lvbl;
    logic             hs;
    logic             vs;
    logic [cnt_w-1:0] h;
    logic [cnt_w-1:0] v;
    logic [6:0]       joy1_out;
    logic [6:0]       joy2_out;
    logic [21:0]      post_addr;

    logic [1:0]       cen_div;
    logic [cnt_w-1:0] mh;
    logic [cnt_w-1:0] mv;
    logic [3:0]       ref_prom [0:2][0:255];
    logic [31:0]      rnd;
    int               errors = 0;
    int               tests_run = 0;
    int               tests_failed = 0;

    arcade_game #(
        .map_start  ( map_start  ),
        .scr_start  ( scr_start  ),
        .obj_start  ( obj_start  ),
        .prom_start ( prom_start )
    ) dut0 (.*);

    always #4 clk = ~clk;

    // Pixel strobe on every fourth clock
    always @(posedge clk) begin
        if (!arst_n) begin
            cen_div <= 2'd0;
            pxl_cen <= 1'b0;
        end else begin
            cen_div <= cen_div + 2'd1;
            pxl_cen <= (cen_div == 2'd3);
        end
    end

    // Reference raster position
    always @(posedge clk) begin
        if (!arst_n) begin
            mh <= '0;
            mv <= '0;
        end else if (pxl_cen) begin
            mh <= (mh == h_total - 9'd1) ? 9'd0 : mh + 9'd1;
            if (mh == h_total - 9'd1) begin
                mv <= (mv == v_total - 9'd1) ? 9'd0 : mv + 9'd1;
            end
        end
    end

    // Called at a falling edge, returns at the falling edge after the strobe
    task automatic wait_strobe();
        int n;
        n = 0;
        while (!pxl_cen && n < 16) begin
            @(negedge clk);
            n++;
        end
        if (pxl_cen) begin
            @(posedge clk);
            @(negedge clk);
        end else begin
            $display("Timeout: no pixel strobe within 16 clocks at %0t", $time);
            $display("Test failed");
            $finish;
        end
    endtask

    task automatic compare_timing(input bit flip);
        logic [cnt_w-1:0] eh;
        logic [cnt_w-1:0] ev;
        logic [3:0]       esync;
        eh = flip ? {mh[8], ~mh[7:0]} : mh;
        ev = flip ? {mv[8], ~mv[7:0]} : mv;
        esync[3] = mh < h_blank_start;
        esync[2] = (mv >= v_blank_end) && (mv < v_blank_start);
        esync[1] = !((mh >= hs_start) && (mh < hs_end));
        esync[0] = !((mv >= vs_start) && (mv < vs_end));
        assert ({h, v, lhbl, lvbl, hs, vs} == {eh, ev, esync}) else begin
            $display("MISMATCH at %0t: raster %0d,%0d flip %0b gives h %0d v %0d syncs %b",
                     $time, mh, mv, flip, h, v, {lhbl, lvbl, hs, vs});
            errors++;
        end
    endtask

    task automatic write_prom(input logic [3:0] bank, input logic [7:0] idx,
                              input logic [7:0] data);
        @(posedge clk);
        ioctl_addr <= prom_start + {14'd0, bank, idx};
        prog_addr  <= prom_start[21:0] + {10'd0, bank, idx};
        prog_data  <= data;
        prom_we    <= 1'b1;
        @(posedge clk);
        prom_we    <= 1'b0;
    endtask

    // kind 1 is the map region, 2 the object region, 0 passes through
    task automatic post_case(input logic [25:0] base, input logic [25:0] span, input int kind);
        logic [25:0] a;
        logic [21:0] p;
        logic [21:0] want;
        rnd = $urandom;
        a = base + (rnd[25:0] % span);
        rnd = $urandom;
        p = rnd[21:0];
        want = p;
        if (kind == 1) begin
            want[0]   = p[3];
            want[3:1] = p[2:0];
        end else if (kind == 2) begin
            want[1]   = p[5];
            want[5:2] = p[4:1];
        end
        @(posedge clk);
        ioctl_addr <= a;
        prog_addr  <= p;
        @(negedge clk);
        assert (post_addr == want) else begin
            $display("MISMATCH at %0t: addr %h prog %h gives %h, expected %h",
                     $time, a, p, post_addr, want);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int mark);
        tests_run++;
        if (errors == mark) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - mark);
        end
    endtask

    task automatic reset_test();
        arst_n <= 1'b1;
        @(negedge clk);
        assert ({h, v, red, green, blue} == 30'd0 && {lhbl, lvbl, hs, vs} == 4'b0011)
        else begin
            $display("MISMATCH at %0t: after reset h %0d v %0d rgb %h syncs %b",
                     $time, h, v, {red, green, blue}, {lhbl, lvbl, hs, vs});
            errors++;
        end
    endtask

    task automatic frame_test();
        int   since;
        int   rises;
        logic prev;
        since = 0;
        rises = 0;
        // Reset blanking does not start a line
        prev  = 1'b1;
        for (int i = 0; i < frame_strobes; i++) begin
            wait_strobe();
            compare_timing(1'b0);
            since++;
            if (lhbl && !prev) begin
                assert (rises == 0 || since == int'(h_total)) else begin
                    $display("MISMATCH at %0t: line took %0d strobes", $time, since);
                    errors++;
                end
                rises++;
                since = 0;
            end
            prev = lhbl;
        end
        assert (rises == int'(v_total)) else begin
            $display("MISMATCH at %0t: %0d lines in one frame", $time, rises);
            errors++;
        end
    endtask

    task automatic prom_test();
        logic [7:0]  code;
        logic [11:0] want;
        logic        act;
        int          seen;
        int          n;
        for (int b = 0; b < 3; b++) begin
            for (int i = 0; i < 256; i++) begin
                rnd = $urandom;
                write_prom(b[3:0], i[7:0], rnd[7:0]);
                ref_prom[b][i] = rnd[3:0];
            end
        end
        // Bank 3 selects no table
        for (int i = 0; i < 32; i++) begin
            rnd = $urandom;
            write_prom(4'd3, rnd[15:8], rnd[7:0]);
        end
        seen = 0;
        n    = 0;
        while (seen < 400 && n < frame_strobes) begin
            rnd  = $urandom;
            code = rnd[7:0];
            @(posedge clk);
            pxl_code <= code;
            @(negedge clk);
            act = (mh < h_blank_start) && (mv >= v_blank_end) && (mv < v_blank_start);
            wait_strobe();
            want = act ? {ref_prom[0][code], ref_prom[1][code], ref_prom[2][code]} : 12'd0;
            assert ({red, green, blue} == want) else begin
                $display("MISMATCH at %0t: code %h active %0b gives rgb %h, expected %h",
                         $time, code, act, {red, green, blue}, want);
                errors++;
            end
            if (act) begin
                seen++;
            end
            n++;
        end
        if (seen < 400) begin
            $display("Only %0d active pixels were seen within one frame", seen);
            errors++;
        end
    endtask

    task automatic post_test();
        for (int i = 0; i < 8; i++) begin
            post_case(26'd0, map_start, 0);
            post_case(map_start, scr_start - map_start, 1);
            post_case(scr_start, obj_start - scr_start, 0);
            post_case(obj_start, prom_start - obj_start, 2);
            post_case(prom_start, 26'd1, 0);
            post_case(prom_start, 26'h100000, 0);
        end
    endtask

    task automatic joy_test();
        logic [6:0] j1;
        logic [6:0] j2;
        logic [6:0] e1;
        logic [6:0] e2;
        for (int i = 0; i < 24; i++) begin
            rnd = $urandom;
            j1  = rnd[6:0];
            j2  = rnd[14:8];
            if (i % 3 == 0) begin
                j1[6] = 1'b1;
            end
            @(posedge clk);
            joystick1 <= j1;
            joystick2 <= j2;
            @(posedge clk);
            @(negedge clk);
            e1 = j1[6] ? (j1 | 7'h30) : j1;
            e2 = j2[6] ? (j2 | 7'h30) : j2;
            assert ({joy1_out, joy2_out} == {e1, e2}) else begin
                $display("MISMATCH at %0t: joysticks %h %h give %h %h, expected %h %h",
                         $time, j1, j2, joy1_out, joy2_out, e1, e2);
                errors++;
            end
        end
    endtask

    task automatic flip_test();
        @(posedge clk);
        dip_flip <= 1'b1;
        @(negedge clk);
        // Two strobes cover the DIP register and the timer update
        wait_strobe();
        wait_strobe();
        for (int i = 0; i < 800; i++) begin
            wait_strobe();
            compare_timing(1'b1);
        end
        @(posedge clk);
        dip_flip <= 1'b0;
        @(negedge clk);
        wait_strobe();
        wait_strobe();
        for (int i = 0; i < 200; i++) begin
            wait_strobe();
            compare_timing(1'b0);
        end
    endtask

    initial begin
        int mark;
        rnd = $urandom(32'h9f442ba7);
        arst_n     <= 1'b0;
        pxl_code   <= 8'd0;
        joystick1  <= 7'd0;
        joystick2  <= 7'd0;
        dip_flip   <= 1'b0;
        ioctl_addr <= 26'd0;
        prog_addr  <= 22'd0;
        prog_data  <= 8'd0;
        prom_we    <= 1'b0;
        repeat (2) @(posedge clk);
        mark = errors;
        reset_test();
        report_test("reset", mark);
        mark = errors;
        frame_test();
        report_test("frame timing", mark);
        mark = errors;
        prom_test();
        report_test("prom lookup", mark);
        mark = errors;
        post_test();
        report_test("sdram address", mark);
        mark = errors;
        joy_test();
        report_test("joystick", mark);
        mark = errors;
        flip_test();
        report_test("screen flip", mark);
        $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== arcade_game.f ====
src/game_pkg.sv
src/video_timer.sv
src/prom_loader.sv
src/cab_input.sv
src/color_mixer.sv
src/arcade_game.sv
sim/arcade_game_checker.sv
sim/arcade_game_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the arcade_game testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module arcade_game_tb -o arcade_game_sim -f arcade_game.f

# A bound assertion may stop the run early
./obj_dir/arcade_game_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "Simulation run OK"
    exit 0
else
    echo "Simulation run FAILED"
    exit 1
fi
